/* flist.f */
+incdir+common
common/mmr_pkg.sv
common/irq_pkg.sv
design/mmr_port.sv
timer/mtime_timer.sv
design/irq_halt_ctrl.sv
design/clint_core.sv
testbench/tb_clint_core.sv

/* Makefile */
# Verilator build and run for the CLINT block

VERILATOR  ?= verilator
TOP        ?= tb_clint_core
RTL_TOP    ?= clint_core
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "No result in $(LOG)"; exit 1; fi
	@echo "Simulation PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_clint_core.sv */
`include "clint_defines.svh"

module tb_clint_core;
   timeunit 1ns;
   timeprecision 100ps;

   import mmr_pkg::*;
   import irq_pkg::*;

   localparam int CLK_HALF   = 10;                       // 20 ns period
   localparam int DRIVE_DLY  = 2;                        // Input skew after the rising edge
   localparam int RST_CYCLES = 8;
   localparam int ACK_LIMIT  = 16;                       // Cycles before giving up on ack
   localparam int IRQ_LIMIT  = 400;                      // Timer interrupt wait bound
   localparam int WAKE_LIMIT = 10;                       // Wake-up wait bound
   localparam logic [`CLINT_DATA_W-1:0] FULL     = 32'hFFFF_FFFF;
   localparam logic [`CLINT_DATA_W-1:0] MSI_W    = 32'd1 << `CLINT_MSI_BIT;
   localparam logic [`CLINT_DATA_W-1:0] MTI_W    = 32'd1 << `CLINT_MTI_BIT;
   localparam logic [`CLINT_DATA_W-1:0] MEI_W    = 32'd1 << `CLINT_MEI_BIT;
   localparam logic [`CLINT_DATA_W-1:0] MIE_MASK = MSI_W | MTI_W | MEI_W;

   // One bus access and what it should return
   typedef struct {
      mmr_kind_e                kind;
      logic [`CLINT_ADDR_W-1:0] ofs;
      logic [`CLINT_DATA_W-1:0] wdata;
      logic [`CLINT_DATA_W-1:0] exp;
      logic [`CLINT_DATA_W-1:0] mask;                    // Zero for don't care
      logic                     fault;
   } row_t;

   logic       clk_in;
   logic       rst;
   logic       ext_irq;
   logic       req;
   mmr_req_t   req_data;
   logic       ack;
   mmr_rsp_t   rsp;
   logic       irq_pending;
   irq_cause_e irq_cause;
   logic       cpu_halt;

   row_t                     rows[$];                    // Stimulus table
   logic                     rows_ready;
   logic [`CLINT_DATA_W-1:0] lcg_state;
   int                       error_count;
   int                       pass_count;
   int                       fail_count;

   clint_core u_clint_core
   (
      .clk_in      (clk_in),
      .rst         (rst),
      .ext_irq     (ext_irq),
      .req         (req),
      .req_data    (req_data),
      .ack         (ack),
      .rsp         (rsp),
      .irq_pending (irq_pending),
      .irq_cause   (irq_cause),
      .cpu_halt    (cpu_halt)
   );

   initial
   begin
      clk_in = 1'b0;
      forever #CLK_HALF clk_in = ~clk_in;
   end

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   function automatic logic [`CLINT_DATA_W-1:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223; // Numerical Recipes constants
      return lcg_state;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk_in);
         #DRIVE_DLY;                                     // Back to the drive point
      end
   endtask

   task automatic check_word(input string what, input logic [`CLINT_DATA_W-1:0] exp,
                             input logic [`CLINT_DATA_W-1:0] act,
                             input logic [`CLINT_DATA_W-1:0] mask);
      if ((act & mask) !== (exp & mask))
      begin
         $display("Mismatch at %0t ns: %s expected %08h got %08h", $time, what,
                  exp & mask, act & mask);
         error_count++;
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("Mismatch at %0t ns: %s expected %b got %b", $time, what, exp, act);
         error_count++;
      end
   endtask

   task automatic check_cause(input string what, input irq_cause_e exp);
      if (irq_cause !== exp)
      begin
         $display("Mismatch at %0t ns: %s expected %s got %s", $time, what, exp.name(),
                  irq_cause.name());
         error_count++;
      end
   endtask

   task automatic close_test(input string name, input int errs_at_start);
      if (error_count == errs_at_start)
      begin
         pass_count++;
         $display("Test %s: pass", name);
      end
      else
      begin
         fail_count++;
         $display("Test %s: FAIL, %0d errors", name, error_count - errs_at_start);
      end
   endtask

   // --------------------------------------------------
   // Four-phase bus master
   // --------------------------------------------------
   task automatic bus_cycle(input mmr_kind_e kind, input logic [`CLINT_ADDR_W-1:0] ofs,
                            input logic [`CLINT_DATA_W-1:0] wdata,
                            output logic [`CLINT_DATA_W-1:0] rdata, output logic fault);
      int n;
      rdata            = '0;
      fault            = 1'b0;
      req_data.addr    = ofs;
      req_data.kind    = kind;
      req_data.wr_data = wdata;
      req              = 1'b1;                           // Payload stable with req
      n                = 0;
      while (!ack && n < ACK_LIMIT)
      begin
         wait_cycles(1);
         n++;
      end
      if (!ack)
      begin
         $display("Bus error at %0t ns: no ack for offset 0x%02h within %0d cycles",
                  $time, ofs, ACK_LIMIT);
         error_count++;
      end
      else
      begin
         rdata = rsp.rd_data;                            // rsp held while ack is high
         fault = rsp.fault;
      end
      req = 1'b0;
      n   = 0;
      while (ack && n < ACK_LIMIT)
      begin
         wait_cycles(1);
         n++;
      end
      if (ack)
      begin
         $display("Bus error at %0t ns: ack stayed high after req dropped", $time);
         error_count++;
      end
   endtask

   task automatic bus_write(input logic [`CLINT_ADDR_W-1:0] ofs,
                            input logic [`CLINT_DATA_W-1:0] data);
      logic [`CLINT_DATA_W-1:0] unused_rd;
      logic                     flt;
      bus_cycle(ACC_WR, ofs, data, unused_rd, flt);
      check_bit($sformatf("fault on write to 0x%02h", ofs), 1'b0, flt);
   endtask

   task automatic bus_read(input logic [`CLINT_ADDR_W-1:0] ofs,
                           output logic [`CLINT_DATA_W-1:0] data);
      logic flt;
      bus_cycle(ACC_RD, ofs, '0, data, flt);
      check_bit($sformatf("fault on read of 0x%02h", ofs), 1'b0, flt);
   endtask

   // --------------------------------------------------
   // Stimulus table
   // --------------------------------------------------
   function automatic void add_row(input mmr_kind_e kind, input logic [`CLINT_ADDR_W-1:0] ofs,
                                   input logic [`CLINT_DATA_W-1:0] wdata,
                                   input logic [`CLINT_DATA_W-1:0] exp,
                                   input logic [`CLINT_DATA_W-1:0] mask, input logic fault);
      row_t r;
      r.kind  = kind;
      r.ofs   = ofs;
      r.wdata = wdata;
      r.exp   = exp;
      r.mask  = mask;
      r.fault = fault;
      rows.push_back(r);
   endfunction

   task automatic build_table();
      logic [`CLINT_DATA_W-1:0] r;
      logic [`CLINT_DATA_W-1:0] mie_val;
      logic [`CLINT_DATA_W-1:0] mip_exp;
      // Reset values
      add_row(ACC_RD, `CLINT_OFS_MSIP, '0, '0, FULL, 1'b0);
      add_row(ACC_RD, `CLINT_OFS_MIE, '0, '0, FULL, 1'b0);
      add_row(ACC_RD, `CLINT_OFS_WFI, '0, '0, FULL, 1'b0);
      add_row(ACC_RD, `CLINT_OFS_MIP, '0, '0, FULL, 1'b0);
      add_row(ACC_RD, `CLINT_OFS_MTIMECMP_LO, '0, FULL, FULL, 1'b0);
      add_row(ACC_RD, `CLINT_OFS_MTIMECMP_HI, '0, FULL, FULL, 1'b0);
      // MIE keeps only the three defined bits
      r       = lcg_next();
      mie_val = r & MIE_MASK;
      add_row(ACC_WR, `CLINT_OFS_MIE, r, '0, '0, 1'b0);
      add_row(ACC_RD, `CLINT_OFS_MIE, '0, mie_val, FULL, 1'b0);
      // MSIP is a single bit, mirrored into MIP
      r       = lcg_next();
      mip_exp = r[0] ? MSI_W : '0;
      add_row(ACC_WR, `CLINT_OFS_MSIP, r, '0, '0, 1'b0);
      add_row(ACC_RD, `CLINT_OFS_MSIP, '0, {31'b0, r[0]}, FULL, 1'b0);
      add_row(ACC_WR, `CLINT_OFS_MIP, lcg_next(), '0, '0, 1'b0);  // Read only
      add_row(ACC_RD, `CLINT_OFS_MIP, '0, mip_exp, FULL, 1'b0);
      // Compare words are stored whole
      r = lcg_next();
      add_row(ACC_WR, `CLINT_OFS_MTIMECMP_LO, r, '0, '0, 1'b0);
      add_row(ACC_RD, `CLINT_OFS_MTIMECMP_LO, '0, r, FULL, 1'b0);
      r = lcg_next();
      add_row(ACC_WR, `CLINT_OFS_MTIMECMP_HI, r, '0, '0, 1'b0);
      add_row(ACC_RD, `CLINT_OFS_MTIMECMP_HI, '0, r, FULL, 1'b0);
      add_row(ACC_WR, `CLINT_OFS_MTIMECMP_HI, FULL, '0, '0, 1'b0);  // Park the compare again
      add_row(ACC_WR, `CLINT_OFS_MTIMECMP_LO, FULL, '0, '0, 1'b0);
      // Unmapped and misaligned, zero data and fault
      add_row(ACC_RD, 8'h20, '0, '0, FULL, 1'b1);
      add_row(ACC_WR, 8'hFC, lcg_next(), '0, FULL, 1'b1);
      add_row(ACC_WR, 8'h02, lcg_next(), '0, FULL, 1'b1);
      add_row(ACC_RD, 8'h02, '0, '0, FULL, 1'b1);
      // Near aliases of MIE, a partial decode would change its value
      add_row(ACC_WR, 8'h06, ~mie_val, '0, FULL, 1'b1);
      add_row(ACC_WR, 8'h24, ~mie_val, '0, FULL, 1'b1);
      add_row(ACC_RD, `CLINT_OFS_MIE, '0, mie_val, FULL, 1'b0);  // Faults wrote nothing
      // Leave a quiet state for the directed tests
      add_row(ACC_WR, `CLINT_OFS_MIE, '0, '0, '0, 1'b0);
      add_row(ACC_WR, `CLINT_OFS_MSIP, '0, '0, '0, 1'b0);
      add_row(ACC_RD, `CLINT_OFS_MIP, '0, '0, FULL, 1'b0);
   endtask

   task automatic apply_table();
      int                       errs;
      logic [`CLINT_DATA_W-1:0] rdata;
      logic                     flt;
      string                    name;
      for (int i = 0; i < rows.size(); i++)
      begin
         errs = error_count;
         name = $sformatf("row %0d %s 0x%02h", i, (rows[i].kind == ACC_WR) ? "WR" : "RD",
                          rows[i].ofs);
         bus_cycle(rows[i].kind, rows[i].ofs, rows[i].wdata, rdata, flt);
         check_word({name, " data"}, rows[i].exp, rdata, rows[i].mask);
         check_bit({name, " fault"}, rows[i].fault, flt);
         close_test(name, errs);
      end
   endtask

   // --------------------------------------------------
   // Directed tests
   // --------------------------------------------------
   task automatic test_priority();
      int errs;
      errs = error_count;
      bus_write(`CLINT_OFS_MIE, MIE_MASK);
      bus_write(`CLINT_OFS_MSIP, 32'd1);
      check_cause("cause with msip", CAUSE_MSI);
      check_bit("irq_pending with msip", 1'b1, irq_pending);
      ext_irq = 1'b1;
      wait_cycles(1);
      check_cause("cause with msip and ext_irq", CAUSE_MEI);  // External beats software
      bus_write(`CLINT_OFS_MIE, MIE_MASK & ~MEI_W);
      check_cause("cause with external masked", CAUSE_MSI);
      bus_write(`CLINT_OFS_MSIP, '0);
      check_cause("cause with msip cleared", CAUSE_NONE);
      check_bit("irq_pending with msip cleared", 1'b0, irq_pending);
      ext_irq = 1'b0;
      bus_write(`CLINT_OFS_MIE, '0);
      close_test("interrupt priority", errs);
   endtask

   task automatic test_timer();
      int                       errs;
      int                       n;
      logic [`CLINT_DATA_W-1:0] t1;
      logic [`CLINT_DATA_W-1:0] t2;
      logic [`CLINT_DATA_W-1:0] w;
      errs = error_count;
      bus_read(`CLINT_OFS_MTIME_LO, t1);
      bus_read(`CLINT_OFS_MTIME_LO, t2);
      if (!(t2 > t1))
      begin
         $display("Mismatch at %0t ns: MTIME_LO expected above %08h got %08h", $time, t1, t2);
         error_count++;
      end
      bus_write(`CLINT_OFS_MIE, MTI_W);
      bus_write(`CLINT_OFS_MTIME_LO, '0);
      bus_write(`CLINT_OFS_MTIME_HI, '0);
      bus_write(`CLINT_OFS_MTIMECMP_LO, 32'd200);
      bus_write(`CLINT_OFS_MTIMECMP_HI, '0);
      check_bit("irq_pending before mtimecmp", 1'b0, irq_pending);  // mtime still small
      n = 0;
      while (!irq_pending && n < IRQ_LIMIT)
      begin
         wait_cycles(1);
         n++;
      end
      if (!irq_pending)
      begin
         $display("Timer interrupt never came within %0d cycles", IRQ_LIMIT);
         error_count++;
      end
      else
      begin
         check_cause("cause with timer", CAUSE_MTI);
         bus_read(`CLINT_OFS_MIP, w);
         check_word("MIP with timer pending", MTI_W, w, FULL);
      end
      bus_write(`CLINT_OFS_MTIMECMP_HI, FULL);
      bus_write(`CLINT_OFS_MTIMECMP_LO, FULL);
      check_bit("irq_pending after mtimecmp parked", 1'b0, irq_pending);
      check_cause("cause after mtimecmp parked", CAUSE_NONE);
      bus_write(`CLINT_OFS_MIE, '0);
      close_test("timer", errs);
   endtask

   task automatic test_halt();
      int                       errs;
      int                       n;
      logic [`CLINT_DATA_W-1:0] w;
      errs = error_count;
      bus_write(`CLINT_OFS_MIE, MEI_W);
      bus_write(`CLINT_OFS_WFI, 32'd1);
      check_bit("cpu_halt after WFI", 1'b1, cpu_halt);
      for (int i = 0; i < 20; i++)
      begin
         wait_cycles(1);
         check_bit($sformatf("cpu_halt %0d cycles into sleep", i + 1), 1'b1, cpu_halt);
      end
      bus_read(`CLINT_OFS_WFI, w);
      check_word("WFI while halted", 32'd1, w, FULL);
      ext_irq = 1'b1;                                    // Enabled source wakes the CPU
      n       = 0;
      while (cpu_halt && n < WAKE_LIMIT)
      begin
         wait_cycles(1);
         n++;
      end
      if (cpu_halt)
      begin
         $display("cpu_halt still set %0d cycles after an enabled ext_irq", WAKE_LIMIT);
         error_count++;
      end
      check_cause("cause at wake", CAUSE_MEI);
      bus_write(`CLINT_OFS_WFI, 32'd1);                  // Pending interrupt blocks sleep
      check_bit("cpu_halt after WFI with pending irq", 1'b0, cpu_halt);
      wait_cycles(3);
      check_bit("cpu_halt later with pending irq", 1'b0, cpu_halt);
      ext_irq = 1'b0;
      bus_write(`CLINT_OFS_MIE, '0);
      close_test("halt and wake", errs);
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial
   begin
      int errs;
      rst         = 1'b1;
      ext_irq     = 1'b0;
      req         = 1'b0;
      req_data    = '0;
      error_count = 0;
      pass_count  = 0;
      fail_count  = 0;
      lcg_state   = 32'd11;                              // Fixed seed
      rows_ready  = 1'b0;
      build_table();
      rows_ready  = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_in);
      #DRIVE_DLY;
      rst = 1'b0;
      wait_cycles(1);
      errs = error_count;
      check_bit("ack after reset", 1'b0, ack);
      check_bit("irq_pending after reset", 1'b0, irq_pending);
      check_bit("cpu_halt after reset", 1'b0, cpu_halt);
      check_cause("cause after reset", CAUSE_NONE);
      close_test("reset outputs", errs);
      apply_table();
      test_priority();
      test_timer();
      test_halt();
      $display("Summary: %0d tests passed, %0d tests failed, %0d errors", pass_count,
               fail_count, error_count);
      if (fail_count == 0 && error_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   // Watchdog, bound scales with the table
   initial
   begin
      int limit;
      wait (rows_ready === 1'b1);
      limit = rows.size() * 20 + 2000;
      repeat (limit) @(posedge clk_in);
      $display("Timeout: the run did not finish within %0d clock cycles", limit);
      $display("Verification failed");
      $finish;
   end

endmodule

/* design/clint_core.sv */
`include "clint_defines.svh"

module clint_core
(
   input  logic                clk_in,
   input  logic                rst,
   input  logic                ext_irq,                  // External interrupt line
   input  logic                req,                      // Four-phase request
   input  mmr_pkg::mmr_req_t   req_data,
   output logic                ack,
   output mmr_pkg::mmr_rsp_t   rsp,
   output logic                irq_pending,
   output irq_pkg::irq_cause_e irq_cause,
   output logic                cpu_halt
);
   import mmr_pkg::*;
   import irq_pkg::*;

   mmr_wr_t     wr;                                      // Port to register owners
   timer_stat_t tstat;                                   // Timer state back to the port
   irq_stat_t   istat;                                   // Interrupt state back to the port
   logic        timer_irq;

   // --------------------------------------------------
   // Register bus slave and decode
   // --------------------------------------------------
   mmr_port u_mmr_port
   (
      .clk_in   (clk_in),
      .rst      (rst),
      .req      (req),
      .req_data (req_data),
      .tstat    (tstat),
      .istat    (istat),
      .ack      (ack),
      .rsp      (rsp),
      .wr       (wr)
   );

   // mtime, mtimecmp and the timer compare
   mtime_timer u_mtime_timer
   (
      .clk_in    (clk_in),
      .rst       (rst),
      .wr        (wr),
      .tstat     (tstat),
      .timer_irq (timer_irq)
   );

   // --------------------------------------------------
   // Enables, priority and CPU sleep
   // --------------------------------------------------
   irq_halt_ctrl u_irq_halt_ctrl
   (
      .clk_in      (clk_in),
      .rst         (rst),
      .wr          (wr),
      .timer_irq   (timer_irq),
      .ext_irq     (ext_irq),
      .istat       (istat),
      .irq_pending (irq_pending),
      .irq_cause   (irq_cause),
      .cpu_halt    (cpu_halt)
   );

endmodule

/* design/irq_halt_ctrl.sv */
`include "clint_defines.svh"

module irq_halt_ctrl
(
   input  logic                clk_in,
   input  logic                rst,
   input  mmr_pkg::mmr_wr_t    wr,                       // Decoded register write
   input  logic                timer_irq,                // From the timer
   input  logic                ext_irq,                  // External interrupt line
   output irq_pkg::irq_stat_t  istat,                    // mie, mip, halted for reads
   output logic                irq_pending,              // Any enabled source active
   output irq_pkg::irq_cause_e irq_cause,                // Highest priority enabled source
   output logic                cpu_halt                  // CPU asleep
);
   import mmr_pkg::*;
   import irq_pkg::*;

   // Only MSI, MTI and MEI exist
   localparam logic [`CLINT_DATA_W-1:0] MIE_WMASK = (1 << `CLINT_MSI_BIT) |
                                                    (1 << `CLINT_MTI_BIT) |
                                                    (1 << `CLINT_MEI_BIT);

   logic                     msip;                       // Software interrupt bit
   logic [`CLINT_DATA_W-1:0] mie;
   logic [`CLINT_DATA_W-1:0] mip;
   logic [`CLINT_DATA_W-1:0] irq_en;                     // Pending and enabled

   // --------------------------------------------------
   // msip and mie registers
   // --------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (rst)
      begin
         msip <= 1'b0;
         mie  <= '0;
      end
      else if (wr.strobe)
      begin
         if (wr.sel == SEL_MSIP)
            msip <= wr.data[0];
         if (wr.sel == SEL_MIE)
            mie <= wr.data & MIE_WMASK;                  // Reserved bits stay zero
      end
   end

   // Pending set, same bit layout as MIE
   always_comb
   begin
      mip                 = '0;
      mip[`CLINT_MSI_BIT] = msip;
      mip[`CLINT_MTI_BIT] = timer_irq;
      mip[`CLINT_MEI_BIT] = ext_irq;
   end

   assign irq_en      = mip & mie;
   assign irq_pending = |irq_en;

   // Priority MEI > MSI > MTI
   always_comb
   begin
      if (irq_en[`CLINT_MEI_BIT])
         irq_cause = CAUSE_MEI;
      else if (irq_en[`CLINT_MSI_BIT])
         irq_cause = CAUSE_MSI;
      else if (irq_en[`CLINT_MTI_BIT])
         irq_cause = CAUSE_MTI;
      else
         irq_cause = CAUSE_NONE;
   end

   // --------------------------------------------------
   // Halt and wake
   // --------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (rst || irq_pending)
         cpu_halt <= 1'b0;                               // Wake wins over a WFI write
      else if (wr.strobe && (wr.sel == SEL_WFI))
         cpu_halt <= 1'b1;
   end

   always_comb
   begin
      istat.mie    = mie;
      istat.mip    = mip;
      istat.halted = cpu_halt;
   end

endmodule

/* timer/mtime_timer.sv */
`include "clint_defines.svh"

module mtime_timer
(
   input  logic                 clk_in,
   input  logic                 rst,
   input  mmr_pkg::mmr_wr_t     wr,                      // Decoded register write
   output irq_pkg::timer_stat_t tstat,                   // Counter state for reads
   output logic                 timer_irq                // mtime >= mtimecmp, registered
);
   import mmr_pkg::*;

   logic [2*`CLINT_DATA_W-1:0] mtime;                    // Free-running counter
   logic [2*`CLINT_DATA_W-1:0] mtimecmp;                 // Compare value
   logic                       wr_time_lo;
   logic                       wr_time_hi;
   logic                       wr_cmp_lo;
   logic                       wr_cmp_hi;

   // Word selects owned by this block
   assign wr_time_lo = wr.strobe && (wr.sel == SEL_MTIME_LO);
   assign wr_time_hi = wr.strobe && (wr.sel == SEL_MTIME_HI);
   assign wr_cmp_lo  = wr.strobe && (wr.sel == SEL_MTIMECMP_LO);
   assign wr_cmp_hi  = wr.strobe && (wr.sel == SEL_MTIMECMP_HI);

   // --------------------------------------------------
   // mtime counter
   // --------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (rst)
         mtime <= '0;
      else if (wr_time_lo)
         mtime <= {mtime[2*`CLINT_DATA_W-1:`CLINT_DATA_W], wr.data}; // Written word wins
      else if (wr_time_hi)
         mtime <= {wr.data, mtime[`CLINT_DATA_W-1:0]};
      else
         mtime <= mtime + 1'b1;                          // One tick per clock
   end

   // --------------------------------------------------
   // mtimecmp register
   // --------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (rst)
         mtimecmp <= `CLINT_MTIMECMP_RST;                // Parked at max
      else if (wr_cmp_lo)
         mtimecmp[`CLINT_DATA_W-1:0] <= wr.data;
      else if (wr_cmp_hi)
         mtimecmp[2*`CLINT_DATA_W-1:`CLINT_DATA_W] <= wr.data;
   end

   // Unsigned compare, one cycle late
   always_ff @(posedge clk_in)
   begin
      if (rst)
         timer_irq <= 1'b0;
      else
         timer_irq <= (mtime >= mtimecmp);
   end

   // Status back to the register port
   always_comb
   begin
      tstat.mtime     = mtime;
      tstat.mtimecmp  = mtimecmp;
      tstat.timer_irq = timer_irq;
   end

endmodule

/* design/mmr_port.sv */
`include "clint_defines.svh"

module mmr_port
(
   input  logic                clk_in,
   input  logic                rst,
   input  logic                req,                      // Four-phase request
   input  mmr_pkg::mmr_req_t   req_data,                 // Stable while req is high
   input  irq_pkg::timer_stat_t tstat,                   // mtime, mtimecmp for reads
   input  irq_pkg::irq_stat_t  istat,                    // mie, mip, halted for reads
   output logic                ack,
   output mmr_pkg::mmr_rsp_t   rsp,
   output mmr_pkg::mmr_wr_t    wr                        // To timer and irq/halt block
);
   import mmr_pkg::*;

   typedef enum logic [1:0] {
      IDLE,                                              // Waiting for req
      ACK,                                               // Request latched, ack goes out next
      WAIT_LOW                                           // ack high until req drops
   } state_e;

   state_e                   state;
   mmr_sel_e                 sel_q;                      // Decoded select of the latched request
   mmr_kind_e                kind_q;
   logic [`CLINT_DATA_W-1:0] data_q;                     // Write payload
   logic [`CLINT_DATA_W-1:0] rd_word;                    // Read mux output

   // Byte address to register select, misaligned words fall to SEL_NONE
   function automatic mmr_sel_e decode_sel(input logic [`CLINT_ADDR_W-1:0] addr);
      mmr_sel_e s;
      s = SEL_NONE;
      if (addr[1:0] == 2'b00)
      begin
         case (addr)
            `CLINT_OFS_MSIP:        s = SEL_MSIP;
            `CLINT_OFS_MIE:         s = SEL_MIE;
            `CLINT_OFS_WFI:         s = SEL_WFI;
            `CLINT_OFS_MIP:         s = SEL_MIP;
            `CLINT_OFS_MTIMECMP_LO: s = SEL_MTIMECMP_LO;
            `CLINT_OFS_MTIMECMP_HI: s = SEL_MTIMECMP_HI;
            `CLINT_OFS_MTIME_LO:    s = SEL_MTIME_LO;
            `CLINT_OFS_MTIME_HI:    s = SEL_MTIME_HI;
            default:                s = SEL_NONE;
         endcase
      end
      return s;
   endfunction

   // --------------------------------------------------
   // Handshake FSM
   // --------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (rst)
      begin
         state <= IDLE;
         ack   <= 1'b0;
         rsp   <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (req)
                  state <= ACK;                          // Request sampled, latch below
            end
            ACK:
            begin
               ack         <= 1'b1;                      // Write lands on this same edge
               rsp.rd_data <= rd_word;                   // Read captured with ack
               rsp.fault   <= (sel_q == SEL_NONE);
               state       <= WAIT_LOW;
            end
            WAIT_LOW:
            begin
               if (!req)
               begin
                  ack   <= 1'b0;                         // Master released, close the cycle
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Request payload, taken once per access
   always_ff @(posedge clk_in)
   begin
      if (state == IDLE && req)
      begin
         sel_q  <= decode_sel(req_data.addr);
         kind_q <= req_data.kind;
         data_q <= req_data.wr_data;
      end
   end

   // --------------------------------------------------
   // Read mux
   // --------------------------------------------------
   always_comb
   begin
      rd_word = '0;                                      // Unmapped reads as zero
      case (sel_q)
         SEL_MSIP:        rd_word[0] = istat.mip[`CLINT_MSI_BIT];
         SEL_MIE:         rd_word    = istat.mie;
         SEL_WFI:         rd_word[0] = istat.halted;
         SEL_MIP:         rd_word    = istat.mip;
         SEL_MTIMECMP_LO: rd_word    = tstat.mtimecmp[`CLINT_DATA_W-1:0];
         SEL_MTIMECMP_HI: rd_word    = tstat.mtimecmp[2*`CLINT_DATA_W-1:`CLINT_DATA_W];
         SEL_MTIME_LO:    rd_word    = tstat.mtime[`CLINT_DATA_W-1:0];
         SEL_MTIME_HI:    rd_word    = tstat.mtime[2*`CLINT_DATA_W-1:`CLINT_DATA_W];
         default:         rd_word    = '0;
      endcase
   end

   // One strobe per access, only in the ACK state, never on a fault
   always_comb
   begin
      wr.strobe = (state == ACK) && (kind_q == ACC_WR) && (sel_q != SEL_NONE);
      wr.sel    = sel_q;
      wr.data   = data_q;
   end

endmodule

/* common/irq_pkg.sv */
`include "clint_defines.svh"

package irq_pkg;

   // Interrupt causes, RISC-V machine cause numbers
   typedef enum logic [3:0] {
      CAUSE_NONE = 4'd0,
      CAUSE_MSI  = 4'd3,                                 // Machine software
      CAUSE_MTI  = 4'd7,                                 // Machine timer
      CAUSE_MEI  = 4'd11                                 // Machine external
   } irq_cause_e;

   // Timer state seen by the register port
   typedef struct packed {
      logic [2*`CLINT_DATA_W-1:0] mtime;
      logic [2*`CLINT_DATA_W-1:0] mtimecmp;
      logic                       timer_irq;
   } timer_stat_t;

   // Interrupt state seen by the register port
   typedef struct packed {
      logic [`CLINT_DATA_W-1:0] mie;
      logic [`CLINT_DATA_W-1:0] mip;
      logic                     halted;                  // CPU asleep
   } irq_stat_t;

endpackage

/* common/mmr_pkg.sv */
`include "clint_defines.svh"

package mmr_pkg;

   // --------------------------------------------------
   // Register selects, one per mapped word
   // --------------------------------------------------
   typedef enum logic [3:0] {
      SEL_MSIP,
      SEL_MIE,
      SEL_WFI,
      SEL_MIP,
      SEL_MTIMECMP_LO,
      SEL_MTIMECMP_HI,
      SEL_MTIME_LO,
      SEL_MTIME_HI,
      SEL_NONE                                           // Unmapped or misaligned
   } mmr_sel_e;

   // Bus access kind
   typedef enum logic {
      ACC_RD = 1'b0,
      ACC_WR = 1'b1
   } mmr_kind_e;

   // Master side of the req/ack bus
   typedef struct packed {
      logic [`CLINT_ADDR_W-1:0] addr;                    // Byte address
      mmr_kind_e                kind;
      logic [`CLINT_DATA_W-1:0] wr_data;
   } mmr_req_t;

   // Slave answer, held while ack is high
   typedef struct packed {
      logic [`CLINT_DATA_W-1:0] rd_data;                 // Zero on fault
      logic                     fault;                   // Unmapped address
   } mmr_rsp_t;

   // Decoded register write, strobe lasts one cycle
   typedef struct packed {
      logic                     strobe;
      mmr_sel_e                 sel;
      logic [`CLINT_DATA_W-1:0] data;
   } mmr_wr_t;

endpackage

/* common/clint_defines.svh */
`ifndef CLINT_DEFINES_SVH
`define CLINT_DEFINES_SVH

// --------------------------------------------------
// Bus and register widths
// --------------------------------------------------
`define CLINT_DATA_W            32                      // Register and bus word width
`define CLINT_ADDR_W            8                       // Byte address width

// --------------------------------------------------
// Register map, byte offsets
// --------------------------------------------------
`define CLINT_OFS_MSIP          8'h00                   // Software interrupt bit
`define CLINT_OFS_MIE           8'h04                   // Interrupt enable mask
`define CLINT_OFS_WFI           8'h08                   // Write puts the CPU to sleep
`define CLINT_OFS_MIP           8'h0C                   // Pending bits, read only
`define CLINT_OFS_MTIMECMP_LO   8'h10
`define CLINT_OFS_MTIMECMP_HI   8'h14
`define CLINT_OFS_MTIME_LO      8'h18
`define CLINT_OFS_MTIME_HI      8'h1C

// Bit positions in MIE and MIP, RISC-V layout
`define CLINT_MSI_BIT           3
`define CLINT_MTI_BIT           7
`define CLINT_MEI_BIT           11

// Compare value that never matches before software sets it
`define CLINT_MTIMECMP_RST      64'hFFFF_FFFF_FFFF_FFFF

`endif
